// File: rtl/m68kBusPkg.sv
// Shared widths, size and acknowledge codes and FSM states; referenced by scoped name everywhere
package m68kBusPkg;

    typedef logic [31:0] addrT;       // Byte address
    typedef logic [31:0] dataT;       // Data bus and operand
    typedef logic [1:0]  sizeT;       // SIZ pin code
    typedef logic [1:0]  dsackT;      // Active low port width
    typedef logic [2:0]  byteCountT;  // 0 to 4 bytes

    // Transfer size codes, four bytes wraps to 00
    localparam sizeT SIZ_BYTE  = 2'b01;
    localparam sizeT SIZ_WORD  = 2'b10;
    localparam sizeT SIZ_THREE = 2'b11;
    localparam sizeT SIZ_LONG  = 2'b00;

    localparam dsackT DSACK_32   = 2'b00;
    localparam dsackT DSACK_16   = 2'b01;
    localparam dsackT DSACK_8    = 2'b10;
    localparam dsackT DSACK_WAIT = 2'b11;

    localparam int RESET_SETTLE_CYCLES = 4;  // Busy cycles after reset

    typedef enum logic [2:0] {
        Settle,
        Idle,
        AddrPhase,
        DataPhase,
        Finish,
        Granted
    } busStateT;

    // Held state renamed so it does not clash with the sequencer's Granted
    typedef enum logic [1:0] {
        Released,
        Granting,
        GrantHeld
    } grantStateT;

endpackage

// File: rtl/busArbiter.sv
// Bus arbiter: hands the bus to an external master when the sequencer is idle, drives the grant pin
`timescale 1ns/100ps

module busArbiter (
    input  logic CLK,
    input  logic in_RESET,
    input  logic busReqN,
    input  logic sequencerIdle,
    output logic busGranted,
    output logic busGrantN
);

    m68kBusPkg::grantStateT grantState;

    // Request seen while idle wins over a host strobe in the same cycle
    assign busGranted = (grantState != m68kBusPkg::Released) || (!busReqN && sequencerIdle);

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            grantState <= m68kBusPkg::Released;
            busGrantN <= 1'b1;
        end else begin
            busGrantN <= (grantState == m68kBusPkg::Released);  // Pin follows one cycle later
            case (grantState)
                m68kBusPkg::Released: begin
                    if (!busReqN && sequencerIdle) begin
                        grantState <= m68kBusPkg::Granting;
                    end
                end
                m68kBusPkg::Granting: begin
                    grantState <= m68kBusPkg::GrantHeld;  // Pin goes low now
                end
                m68kBusPkg::GrantHeld: begin
                    if (busReqN) begin
                        grantState <= m68kBusPkg::Released;
                    end
                end
                default: begin
                    grantState <= m68kBusPkg::Released;
                end
            endcase
        end
    end

endmodule

// File: rtl/cycleSequencer.sv
// Bus-cycle FSM: takes a host request, runs address/data/finish phases and splits the operand
`timescale 1ns/100ps

module cycleSequencer (
    input  logic                  CLK,
    input  logic                  in_RESET,
    input  logic                  reqValid,
    input  logic                  reqWrite,
    input  m68kBusPkg::addrT      reqAddr,
    input  m68kBusPkg::sizeT      reqSize,
    input  logic                  busGranted,
    input  m68kBusPkg::byteCountT bytesMoved,
    input  m68kBusPkg::dsackT     dsack,
    output logic                  busy,
    output logic                  done,
    output logic                  sequencerIdle,
    output logic                  cycleWrite,
    output m68kBusPkg::addrT      addr,
    output m68kBusPkg::sizeT      size,
    output logic                  rnw,
    output logic                  addrStrobeN,
    output logic                  dataStrobeN,
    output logic                  dataOutEn,
    output logic                  latchRead,
    output m68kBusPkg::addrT      opStartAddr
);

    m68kBusPkg::busStateT  state;
    m68kBusPkg::byteCountT remBytes;
    m68kBusPkg::byteCountT leftBytes;
    logic [2:0]            settleCount;
    logic                  opWrite;
    logic                  lastCycle;    // Current bus cycle ends the operand
    logic                  ackSeen;
    logic                  startOp;

    assign remBytes = (size == m68kBusPkg::SIZ_LONG) ? 3'd4 : {1'b0, size};
    assign leftBytes = remBytes - bytesMoved;
    assign ackSeen = (state == m68kBusPkg::DataPhase) && (dsack != m68kBusPkg::DSACK_WAIT);
    assign startOp = (state == m68kBusPkg::Idle) && reqValid && !busGranted;

    assign busy = (state != m68kBusPkg::Idle);
    assign sequencerIdle = (state == m68kBusPkg::Idle);
    assign done = (state == m68kBusPkg::Finish) && lastCycle;
    assign cycleWrite = opWrite;
    assign rnw = !opWrite;
    assign latchRead = ackSeen && !opWrite;  // Read lanes sampled on this edge

    // Strobes and enable are all dropped while the external master owns the bus
    assign addrStrobeN = busGranted || !((state == m68kBusPkg::AddrPhase) ||
                                         (state == m68kBusPkg::DataPhase));
    assign dataStrobeN = busGranted || !((state == m68kBusPkg::DataPhase) ||
                                         (state == m68kBusPkg::AddrPhase && !opWrite));
    assign dataOutEn = !busGranted && (state == m68kBusPkg::DataPhase) && opWrite;

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state <= m68kBusPkg::Settle;
            settleCount <= '0;
            opWrite <= 1'b0;
            lastCycle <= 1'b0;
        end else begin
            case (state)
                m68kBusPkg::Settle: begin
                    if (settleCount == 3'(m68kBusPkg::RESET_SETTLE_CYCLES - 1)) begin
                        state <= m68kBusPkg::Idle;
                    end else begin
                        settleCount <= settleCount + 3'd1;
                    end
                end
                m68kBusPkg::Idle: begin
                    if (busGranted) begin
                        state <= m68kBusPkg::Granted;
                    end else if (reqValid) begin
                        state <= m68kBusPkg::AddrPhase;
                        opWrite <= reqWrite;
                    end
                end
                m68kBusPkg::AddrPhase: begin
                    state <= m68kBusPkg::DataPhase;
                end
                m68kBusPkg::DataPhase: begin
                    if (ackSeen) begin  // Wait states stretch this phase only
                        state <= m68kBusPkg::Finish;
                        lastCycle <= (leftBytes == 3'd0);
                    end
                end
                m68kBusPkg::Finish: begin
                    state <= lastCycle ? m68kBusPkg::Idle : m68kBusPkg::AddrPhase;
                end
                m68kBusPkg::Granted: begin
                    if (!busGranted) begin
                        state <= m68kBusPkg::Idle;
                    end
                end
                default: begin
                    state <= m68kBusPkg::Idle;
                end
            endcase
        end
    end

    // Address and remaining size of the operand
    always_ff @(posedge CLK) begin
        if (startOp) begin
            addr <= reqAddr;
            size <= reqSize;
            opStartAddr <= reqAddr;
        end else if (ackSeen) begin
            addr <= addr + m68kBusPkg::addrT'(bytesMoved);
            size <= leftBytes[1:0];
        end
    end

endmodule

// File: rtl/portSizer.sv
// Bytes moved by the current bus cycle, from remaining size, address alignment and port width
`timescale 1ns/100ps

module portSizer (
    input  m68kBusPkg::addrT      addr,
    input  m68kBusPkg::sizeT      size,
    input  m68kBusPkg::dsackT     dsack,
    output m68kBusPkg::byteCountT bytesMoved
);

    m68kBusPkg::byteCountT remBytes;
    m68kBusPkg::byteCountT portBytes;  // Room left on the port from this address

    assign remBytes = (size == m68kBusPkg::SIZ_LONG) ? 3'd4 : {1'b0, size};

    always_comb begin
        case (dsack)
            m68kBusPkg::DSACK_32: portBytes = 3'd4 - {1'b0, addr[1:0]};
            m68kBusPkg::DSACK_16: portBytes = 3'd2 - {2'b00, addr[0]};
            m68kBusPkg::DSACK_8:  portBytes = 3'd1;
            default:              portBytes = 3'd0;  // Still waiting
        endcase
    end

    assign bytesMoved = (remBytes < portBytes) ? remBytes : portBytes;

endmodule

// File: rtl/byteLaneSteering.sv
// Byte lane steering: replicates write bytes onto data lanes and gathers read bytes into rdData
`timescale 1ns/100ps

module byteLaneSteering (
    input  logic              CLK,
    input  logic              in_RESET,
    input  logic              reqValid,
    input  logic              busy,
    input  m68kBusPkg::dataT  reqData,
    input  logic              cycleWrite,
    input  m68kBusPkg::addrT  addr,
    input  m68kBusPkg::sizeT  size,
    input  m68kBusPkg::addrT  opStartAddr,
    input  m68kBusPkg::dataT  dataIn,
    input  m68kBusPkg::dsackT dsack,
    input  logic              latchRead,
    output m68kBusPkg::dataT  dataOut,
    output m68kBusPkg::dataT  rdData
);

    m68kBusPkg::dataT      opData;      // Write operand, right-justified
    m68kBusPkg::dataT      readAcc;
    m68kBusPkg::dataT      readMerged;
    m68kBusPkg::dataT      readResult;
    m68kBusPkg::dataT      laneData;
    m68kBusPkg::byteCountT opOffset;    // Bytes already moved
    m68kBusPkg::byteCountT opBytes;     // Whole operand size
    logic                  lastLatch;

    // Operand byte offset carried by a lane; lane 0 is D31:24
    function automatic logic [1:0] laneOffset(input logic [1:0] lane, input logic [1:0] low);
        logic [1:0] k;
        if (lane >= low) begin
            k = lane - low;
        end else if (lane == 2'd1) begin
            k = 2'd1 - {1'b0, low[0]};  // Upper half of a 16-bit port
        end else if (lane == 2'd0) begin
            k = 2'd0;  // 8-bit port always sees the first byte
        end else begin
            k = 2'd1;
        end
        return k;
    endfunction

    function automatic logic laneUsed(input logic [1:0] lane, input logic [1:0] low,
                                      input m68kBusPkg::dsackT ack);
        logic used;
        case (ack)
            m68kBusPkg::DSACK_32: used = (lane >= low);
            m68kBusPkg::DSACK_16: used = (lane <= 2'd1) && (lane >= {1'b0, low[0]});
            m68kBusPkg::DSACK_8:  used = (lane == 2'd0);
            default:              used = 1'b0;
        endcase
        return used;
    endfunction

    assign opOffset = {1'b0, addr[1:0] - opStartAddr[1:0]};
    assign opBytes = opOffset + ((size == m68kBusPkg::SIZ_LONG) ? 3'd4 : {1'b0, size});

    always_comb begin
        logic [1:0]            lane;
        m68kBusPkg::byteCountT idx;
        m68kBusPkg::byteCountT pos;
        laneData = '0;
        readMerged = readAcc;
        lastLatch = 1'b0;
        for (int l = 0; l < 4; l++) begin
            lane = 2'(l);
            idx = opOffset + {1'b0, laneOffset(lane, addr[1:0])};
            pos = opBytes - 3'd1 - idx;  // Byte position in the right-justified operand
            if (idx < opBytes) begin
                laneData[(3 - l) * 8 +: 8] = opData[pos[1:0] * 8 +: 8];
                if (laneUsed(lane, addr[1:0], dsack)) begin
                    readMerged[pos[1:0] * 8 +: 8] = dataIn[(3 - l) * 8 +: 8];
                    if (pos == 3'd0) begin
                        lastLatch = 1'b1;
                    end
                end
            end
        end
    end

    // Zero the bytes above the operand
    always_comb begin
        readResult = readMerged;
        for (int p = 0; p < 4; p++) begin
            if (p >= int'(opBytes)) begin
                readResult[p * 8 +: 8] = 8'h00;
            end
        end
    end

    assign dataOut = cycleWrite ? laneData : '0;

    always_ff @(posedge CLK) begin
        if (reqValid && !busy) begin
            opData <= reqData;
        end
        if (latchRead) begin
            readAcc <= readMerged;
        end
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            rdData <= '0;
        end else if (latchRead && lastLatch) begin
            rdData <= readResult;  // Only on the final byte of a read
        end
    end

endmodule

// File: rtl/m68kBusInterface.sv
// Top of the 68020-style bus interface with dynamic bus sizing; host request side and external bus
`timescale 1ns/100ps

module m68kBusInterface (
    input  logic              CLK,
    input  logic              in_RESET,
    input  logic              reqValid,
    input  logic              reqWrite,
    input  m68kBusPkg::addrT  reqAddr,
    input  m68kBusPkg::sizeT  reqSize,
    input  m68kBusPkg::dataT  reqData,
    output logic              busy,
    output logic              done,
    output m68kBusPkg::dataT  rdData,
    output m68kBusPkg::addrT  addr,
    output m68kBusPkg::dataT  dataOut,
    output logic              dataOutEn,
    output m68kBusPkg::sizeT  size,
    output logic              rnw,
    output logic              addrStrobeN,
    output logic              dataStrobeN,
    input  m68kBusPkg::dataT  dataIn,
    input  m68kBusPkg::dsackT dsack,
    input  logic              busReqN,
    output logic              busGrantN
);

    logic                  sequencerIdle;
    logic                  busGranted;
    logic                  cycleWrite;
    logic                  latchRead;
    m68kBusPkg::byteCountT bytesMoved;
    m68kBusPkg::addrT      opStartAddr;

    busArbiter busArbiter_inst (
        .CLK           (CLK),
        .in_RESET      (in_RESET),
        .busReqN       (busReqN),
        .sequencerIdle (sequencerIdle),
        .busGranted    (busGranted),
        .busGrantN     (busGrantN)
    );

    cycleSequencer cycleSequencer_inst (
        .CLK           (CLK),
        .in_RESET      (in_RESET),
        .reqValid      (reqValid),
        .reqWrite      (reqWrite),
        .reqAddr       (reqAddr),
        .reqSize       (reqSize),
        .busGranted    (busGranted),
        .bytesMoved    (bytesMoved),
        .dsack         (dsack),
        .busy          (busy),
        .done          (done),
        .sequencerIdle (sequencerIdle),
        .cycleWrite    (cycleWrite),
        .addr          (addr),
        .size          (size),
        .rnw           (rnw),
        .addrStrobeN   (addrStrobeN),
        .dataStrobeN   (dataStrobeN),
        .dataOutEn     (dataOutEn),
        .latchRead     (latchRead),
        .opStartAddr   (opStartAddr)
    );

    portSizer portSizer_inst (
        .addr       (addr),
        .size       (size),
        .dsack      (dsack),
        .bytesMoved (bytesMoved)
    );

    byteLaneSteering byteLaneSteering_inst (
        .CLK         (CLK),
        .in_RESET    (in_RESET),
        .reqValid    (reqValid),
        .busy        (busy),
        .reqData     (reqData),
        .cycleWrite  (cycleWrite),
        .addr        (addr),
        .size        (size),
        .opStartAddr (opStartAddr),
        .dataIn      (dataIn),
        .dsack       (dsack),
        .latchRead   (latchRead),
        .dataOut     (dataOut),
        .rdData      (rdData)
    );

endmodule

// File: testbench/busSlaveModel.sv
// Bus slave memory for the testbench: 16 KB, port width chosen by address region, random waits
`timescale 1ns/100ps

module busSlaveModel (
    input  logic              CLK,
    input  logic              in_RESET,
    input  m68kBusPkg::addrT  addr,
    input  m68kBusPkg::sizeT  size,
    input  logic              rnw,
    input  logic              addrStrobeN,
    input  m68kBusPkg::dataT  dataOut,
    input  logic              dataOutEn,
    output m68kBusPkg::dataT  dataIn,
    output m68kBusPkg::dsackT dsack
);

    logic [7:0]        mem [0:16383];
    logic              active;      // Bus cycle under way
    logic [1:0]        waitLeft;
    m68kBusPkg::dsackT portAck;
    int                portLanes;
    int                firstLane;   // Lane carrying the byte at addr
    int                moveCount;
    logic [13:0]       laneBase;    // Address seen on lane D31:24

    function automatic logic [7:0] fillByte(input logic [13:0] a);
        return a[7:0] ^ {a[13:8], a[13:12]};
    endfunction

    // Region 01 is a 16-bit port, 10 an 8-bit port, the rest 32-bit
    always_comb begin
        case (addr[13:12])
            2'b01: begin
                portAck = m68kBusPkg::DSACK_16;
                portLanes = 2;
                firstLane = int'(addr[0]);
            end
            2'b10: begin
                portAck = m68kBusPkg::DSACK_8;
                portLanes = 1;
                firstLane = 0;
            end
            default: begin
                portAck = m68kBusPkg::DSACK_32;
                portLanes = 4;
                firstLane = int'(addr[1:0]);
            end
        endcase
        laneBase = addr[13:0] - 14'(firstLane);
        moveCount = portLanes - firstLane;
        if (size != m68kBusPkg::SIZ_LONG && int'(size) < moveCount) begin
            moveCount = int'(size);
        end
    end

    assign dsack = (active && waitLeft == 2'd0 && !addrStrobeN) ? portAck :
                                                                m68kBusPkg::DSACK_WAIT;

    // Reads return the whole port on its own lanes
    always_comb begin
        dataIn = '0;
        for (int k = 0; k < 4; k++) begin
            if (k < portLanes) begin
                dataIn[(3 - k) * 8 +: 8] = mem[laneBase + 14'(k)];
            end
        end
    end

    always @(posedge CLK) begin
        if (!in_RESET) begin
            active <= 1'b0;
            waitLeft <= 2'd0;
            for (int a = 0; a < 16384; a++) begin
                mem[a] <= fillByte(14'(a));
            end
        end else if (addrStrobeN) begin
            active <= 1'b0;
        end else if (!active) begin
            active <= 1'b1;
            waitLeft <= 2'($urandom_range(3, 0));  // Wait states for this cycle
        end else if (waitLeft != 2'd0) begin
            waitLeft <= waitLeft - 2'd1;
        end else if (!rnw && dataOutEn) begin
            for (int i = 0; i < moveCount; i++) begin
                mem[laneBase + 14'(firstLane + i)] <= dataOut[(3 - firstLane - i) * 8 +: 8];
            end
        end
    end

endmodule

// File: testbench/tbM68kBus.sv
// Testbench for the bus interface: random host operations and bus requests against a memory model
`timescale 1ns/100ps

module tbM68kBus;

    localparam int NUM_OPS = 300;
    localparam int CYCLE_LIMIT = NUM_OPS * 40;
    localparam logic [31:0] WINDOW_BASE = 32'h0004_0000;

    logic                  CLK;
    logic                  in_RESET;
    logic                  reqValid;
    logic                  reqWrite;
    m68kBusPkg::addrT      reqAddr;
    m68kBusPkg::sizeT      reqSize;
    m68kBusPkg::dataT      reqData;
    logic                  busy;
    logic                  done;
    m68kBusPkg::dataT      rdData;
    m68kBusPkg::addrT      addr;
    m68kBusPkg::dataT      dataOut;
    logic                  dataOutEn;
    m68kBusPkg::sizeT      size;
    logic                  rnw;
    logic                  addrStrobeN;
    logic                  dataStrobeN;
    m68kBusPkg::dataT      dataIn;
    m68kBusPkg::dsackT     dsack;
    logic                  busReqN;
    logic                  busGrantN;

    logic [7:0] refMem [0:16383];  // Mirror of the slave memory
    int         errors;
    int         checks;
    int         cycleCount = 0;

    m68kBusInterface m68kBusInterface_inst (
        .CLK(CLK), .in_RESET(in_RESET), .reqValid(reqValid), .reqWrite(reqWrite),
        .reqAddr(reqAddr), .reqSize(reqSize), .reqData(reqData), .busy(busy),
        .done(done), .rdData(rdData), .addr(addr), .dataOut(dataOut),
        .dataOutEn(dataOutEn), .size(size), .rnw(rnw), .addrStrobeN(addrStrobeN),
        .dataStrobeN(dataStrobeN), .dataIn(dataIn), .dsack(dsack),
        .busReqN(busReqN), .busGrantN(busGrantN)
    );

    busSlaveModel busSlaveModel_inst (
        .CLK(CLK), .in_RESET(in_RESET), .addr(addr), .size(size), .rnw(rnw),
        .addrStrobeN(addrStrobeN), .dataOut(dataOut), .dataOutEn(dataOutEn),
        .dataIn(dataIn), .dsack(dsack)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: no finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    function automatic logic [7:0] fillByte(input logic [13:0] a);
        return a[7:0] ^ {a[13:8], a[13:12]};
    endfunction

    // Bytes a port takes from this address, by region width
    function automatic int bytesThisCycle(input logic [31:0] a, input int rem);
        int room;
        case (a[13:12])
            2'b01:   room = 2 - int'(a[0]);
            2'b10:   room = 1;
            default: room = 4 - int'(a[1:0]);
        endcase
        return (rem < room) ? rem : room;
    endfunction

    function automatic int countCycles(input logic [31:0] a, input int n);
        int cycles;
        int moved;
        cycles = 0;
        while (n > 0) begin
            moved = bytesThisCycle(a, n);
            a = a + 32'(moved);
            n = n - moved;
            cycles++;
        end
        return cycles;
    endfunction

    function automatic logic [31:0] refRead(input logic [31:0] a, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[23:0], refMem[a[13:0] + 14'(i)]};
        end
        return v;
    endfunction

    task automatic refWrite(input logic [31:0] a, input int n, input logic [31:0] data);
        for (int i = 0; i < n; i++) begin
            refMem[a[13:0] + 14'(i)] = data[(n - 1 - i) * 8 +: 8];  // MSB at lowest address
        end
    endtask

    task automatic runOperation(input logic write, input logic [31:0] a, input int n,
                                input logic [31:0] data);
        logic [31:0] expAddr;
        logic [31:0] expRead;
        int          expRem;
        int          moved;
        int          asFalls;
        logic        prevAs;
        logic        finished;
        expAddr = a;
        expRem = n;
        expRead = refRead(a, n);
        asFalls = 0;
        prevAs = 1'b1;
        finished = 1'b0;
        reqValid = 1'b1;
        reqWrite = write;
        reqAddr = a;
        reqSize = 2'(n);
        reqData = data;
        @(negedge CLK);
        reqValid = 1'b0;
        while (!finished) begin
            if (!addrStrobeN && prevAs) begin  // New address phase
                asFalls++;
                checkValue("addr", addr, expAddr);
                checkValue("size", 32'(size), 32'(expRem % 4));
                checkValue("rnw", 32'(rnw), 32'(!write));
                checkValue("dataStrobeN", 32'(dataStrobeN), 32'(write));
                checkValue("dataOutEn", 32'(dataOutEn), 32'd0);
                moved = bytesThisCycle(expAddr, expRem);
                expAddr = expAddr + 32'(moved);
                expRem = expRem - moved;
            end else if (!addrStrobeN) begin  // Data phase
                checkValue("dataStrobeN", 32'(dataStrobeN), 32'd0);
                checkValue("dataOutEn", 32'(dataOutEn), 32'(write));
            end
            prevAs = addrStrobeN;
            if (done) begin
                finished = 1'b1;
                checkValue("dataStrobeN", 32'(dataStrobeN), 32'd1);
                checkValue("addrStrobeN falls", 32'(asFalls), 32'(countCycles(a, n)));
                if (!write) begin
                    checkValue("rdData", rdData, expRead);
                end
            end else begin
                @(negedge CLK);
            end
        end
        if (write) begin
            refWrite(a, n, data);
        end
    endtask

    // External master holds the bus; a host strobe meanwhile must be ignored
    task automatic grantBus(input int holdCycles);
        busReqN = 1'b0;
        @(negedge CLK);
        checkValue("busGrantN", 32'(busGrantN), 32'd1);
        checkValue("busy", 32'(busy), 32'd1);
        @(negedge CLK);
        for (int k = 0; k < holdCycles; k++) begin
            checkValue("busGrantN", 32'(busGrantN), 32'd0);
            checkValue("addrStrobeN", 32'(addrStrobeN), 32'd1);
            checkValue("busy", 32'(busy), 32'd1);
            reqValid = (k == 0);
            @(negedge CLK);
        end
        reqValid = 1'b0;
        busReqN = 1'b1;
        @(negedge CLK);
        checkValue("busGrantN", 32'(busGrantN), 32'd0);
        checkValue("busy", 32'(busy), 32'd1);
        @(negedge CLK);
        checkValue("busGrantN", 32'(busGrantN), 32'd1);
    endtask

    initial begin
        int          waitCycles;
        logic        opWrite;
        int          opBytes;
        logic [31:0] opAddr;
        logic [31:0] lastWriteAddr;
        void'($urandom(54402));
        errors = 0;
        checks = 0;
        in_RESET = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqSize = m68kBusPkg::SIZ_BYTE;
        reqData = '0;
        busReqN = 1'b1;
        lastWriteAddr = WINDOW_BASE;
        for (int a = 0; a < 16384; a++) begin
            refMem[a] = fillByte(14'(a));
        end
        repeat (5) @(negedge CLK);
        checkValue("addrStrobeN", 32'(addrStrobeN), 32'd1);
        checkValue("dataStrobeN", 32'(dataStrobeN), 32'd1);
        checkValue("busGrantN", 32'(busGrantN), 32'd1);
        checkValue("done", 32'(done), 32'd0);
        checkValue("dataOutEn", 32'(dataOutEn), 32'd0);
        in_RESET = 1'b1;
        waitCycles = 0;
        while (busy && waitCycles < m68kBusPkg::RESET_SETTLE_CYCLES + 1) begin
            @(negedge CLK);
            waitCycles++;
        end
        checkValue("busy", 32'(busy), 32'd0);
        for (int op = 0; op < NUM_OPS; op++) begin
            while (busy) @(negedge CLK);
            if ($urandom_range(9, 0) == 0) begin
                grantBus(int'($urandom_range(6, 1)));
                while (busy) @(negedge CLK);
            end
            opWrite = 1'($urandom_range(1, 0));
            opBytes = int'($urandom_range(4, 1));
            if (!opWrite && $urandom_range(1, 0) == 1) begin
                opAddr = lastWriteAddr;  // Read back a recent write
            end else begin
                opAddr = WINDOW_BASE + $urandom_range(32'h3FFC, 0);
            end
            if (opWrite) begin
                lastWriteAddr = opAddr;
            end
            runOperation(opWrite, opAddr, opBytes, $urandom());
        end
        @(negedge CLK);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/m68kBusPkg.sv
rtl/busArbiter.sv
rtl/cycleSequencer.sv
rtl/portSizer.sv
rtl/byteLaneSteering.sv
rtl/m68kBusInterface.sv
testbench/busSlaveModel.sv
testbench/tbM68kBus.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tbM68kBus -f filelist.f -o simM68kBus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simM68kBus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
